//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbGpioBank
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
logic/gpioPkg.sv
logic/gpioCtrlIf.sv
logic/gpioTickGen.sv
logic/gpioCmdDecoder.sv
logic/gpioCell.sv
logic/gpioBank.sv
tb/gpioChecker.sv
tb/tbGpioBank.sv

//--- logic/gpioBank.sv
`timescale 1ns/1ps

module gpioBank (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmdValid,
    input  gpioPkg::gpioOpT   cmdOp,
    input  gpioPkg::cellAddrT cmdAddr,
    input  gpioPkg::cmdDataT  cmdData,
    output logic              cmdCredit,
    output logic              rdValid,
    output gpioPkg::cellAddrT rdAddr,
    output logic [1:0]        rdData,
    input  gpioPkg::pinVecT   ioIn,
    output gpioPkg::pinVecT   ioOut,
    output gpioPkg::pinVecT   ioOutEn
);
    import gpioPkg::*;

    logic tick;

    gpioCtrlIf ctrlBus ();

    gpioTickGen u_tickGen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    gpioCmdDecoder u_cmdDecoder (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdCredit (cmdCredit),
        .rdValid   (rdValid),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .ctrl      (ctrlBus.decoder)
    );

    // Each cell takes its own bit of every per-cell field
    for (genvar i = 0; i < NUM_CELLS; i++) begin : gCell
        gpioCell u_cell (
            .clk       (clk),
            .reset     (reset),
            .tick      (tick),
            .set       (ctrlBus.set[i]),
            .clear     (ctrlBus.clear[i]),
            .pulseInit (ctrlBus.pulseInit[i]),
            .data      (ctrlBus.data),
            .ioIn      (ioIn[i]),
            .localOut  (ctrlBus.localOut[i]),
            .pinIn     (ctrlBus.pinIn[i]),
            .ioOut     (ioOut[i]),
            .ioOutEn   (ioOutEn[i])
        );
    end

endmodule

//--- logic/gpioCell.sv
`timescale 1ns/1ps

module gpioCell (
    input  logic             clk,
    input  logic             reset,
    input  logic             tick,
    input  logic             set,
    input  logic             clear,
    input  logic             pulseInit,
    input  gpioPkg::cmdDataT data,
    input  logic             ioIn,
    output logic             localOut,
    output logic             pinIn,
    output logic             ioOut,
    output logic             ioOutEn
);
    import gpioPkg::*;

    logic [PULSE_W-1:0] pulseCnt;
    logic               pulseActive;
    logic               pulseLast;
    logic               level;
    logic               enable;

    assign pulseActive = pulseCnt[PULSE_W-1];
    assign pulseLast   = (pulseCnt[DATA_W-1:0] == DATA_W'(1));

    // Input sampler
    always_ff @(posedge clk) begin
        if (reset) begin
            pinIn <= 1'b0;
        end else if (tick) begin
            pinIn <= ioIn;
        end
    end

    // Pulse counter, a new pulse restarts the count
    always_ff @(posedge clk) begin
        if (reset) begin
            pulseCnt <= '0;
        end else if (tick) begin
            if (pulseInit) begin
                pulseCnt <= {1'b1, data};
            end else if (pulseActive) begin
                // Flag drops together with the final decrement
                pulseCnt <= {!pulseLast, pulseCnt[DATA_W-1:0] - 1'b1};
            end
        end
    end

    // Stored level and enable
    always_ff @(posedge clk) begin
        if (reset) begin
            level  <= 1'b0;
            enable <= 1'b0;
        end else if (tick) begin
            if (set) begin
                level  <= data[0];
                enable <= 1'b1;
            end else if (clear) begin
                level  <= 1'b0;
                enable <= 1'b0;
            end
        end
    end

    // A running pulse inverts the stored level
    assign localOut = level ^ pulseActive;

    // Pin outputs lag the internal state by one tick
    always_ff @(posedge clk) begin
        if (reset) begin
            ioOut   <= 1'b0;
            ioOutEn <= 1'b0;
        end else if (tick) begin
            ioOut   <= localOut;
            ioOutEn <= enable | pulseActive;
        end
    end

    a_setClearExclusive : assert property (
        @(posedge clk) disable iff (reset)
        !(set && clear)
    );

endmodule

//--- logic/gpioCmdDecoder.sv
`timescale 1ns/1ps

module gpioCmdDecoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              tick,
    input  logic              cmdValid,
    input  gpioPkg::gpioOpT   cmdOp,
    input  gpioPkg::cellAddrT cmdAddr,
    input  gpioPkg::cmdDataT  cmdData,
    output logic              cmdCredit,
    output logic              rdValid,
    output gpioPkg::cellAddrT rdAddr,
    output logic [1:0]        rdData,
    gpioCtrlIf.decoder        ctrl
);
    import gpioPkg::*;

    // Queue storage
    gpioOpT            opQ   [CMD_CREDITS];
    cellAddrT          addrQ [CMD_CREDITS];
    cmdDataT           dataQ [CMD_CREDITS];

    logic [QPTR_W-1:0] wrPtr;
    logic [QPTR_W-1:0] rdPtr;
    logic [QPTR_W:0]   count;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;
    gpioOpT            headOp;
    cellAddrT          headAddr;

    assign full  = (count == (QPTR_W + 1)'(CMD_CREDITS));
    assign empty = (count == '0);

    // Host only pushes with a credit in hand, so no full check here
    assign push = cmdValid;
    assign pop  = tick && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            opQ[wrPtr]   <= cmdOp;
            addrQ[wrPtr] <= cmdAddr;
            dataQ[wrPtr] <= cmdData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == QPTR_W'(CMD_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == QPTR_W'(CMD_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign headOp   = opQ[rdPtr];
    assign headAddr = addrQ[rdPtr];

    // Credit goes back in the cycle the head leaves the queue
    assign cmdCredit = pop;

    // Issue: one strobe for the addressed cell
    always_comb begin
        ctrl.set       = '0;
        ctrl.clear     = '0;
        ctrl.pulseInit = '0;
        if (pop) begin
            case (headOp)
                OP_WRITE:   ctrl.set[headAddr] = 1'b1;
                OP_RELEASE: ctrl.clear[headAddr] = 1'b1;
                OP_PULSE:   ctrl.pulseInit[headAddr] = 1'b1;
                default:    ;
            endcase
        end
    end

    assign ctrl.data = dataQ[rdPtr];

    // Read response uses cell status as of the previous tick
    assign rdValid = pop && (headOp == OP_READ);
    assign rdAddr  = headAddr;
    assign rdData  = {ctrl.localOut[headAddr], ctrl.pinIn[headAddr]};

    // Host must respect its credits
    a_noPushWhenFull : assert property (
        @(posedge clk) disable iff (reset)
        cmdValid |-> !full
    );

    // Only one kind of strobe reaches the cells, and only on a tick
    a_oneStrobeClass : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({|ctrl.set, |ctrl.clear, |ctrl.pulseInit}) &&
        ((|{ctrl.set, ctrl.clear, ctrl.pulseInit}) -> tick)
    );

endmodule

//--- logic/gpioCtrlIf.sv
`timescale 1ns/1ps

interface gpioCtrlIf;
    import gpioPkg::*;

    // One-hot strobes per cell, only high in a tick cycle
    pinVecT  set;
    pinVecT  clear;
    pinVecT  pulseInit;

    // Data of the issued command, shared by all cells
    cmdDataT data;

    // Status back from each cell
    pinVecT  localOut;
    pinVecT  pinIn;

    modport decoder (
        output set,
        output clear,
        output pulseInit,
        output data,
        input  localOut,
        input  pinIn
    );

    modport cells (
        input  set,
        input  clear,
        input  pulseInit,
        input  data,
        output localOut,
        output pinIn
    );

endinterface

//--- logic/gpioPkg.sv
package gpioPkg;

    // Bank geometry
    localparam int NUM_CELLS = 8;
    localparam int ADDR_W = 3;
    localparam int DATA_W = 10;

    // Clocks per tick of the shared clock enable
    localparam int TICK_DIV = 4;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);

    // Queue depth, equal to the credits the host holds after reset
    localparam int CMD_CREDITS = 4;
    localparam int QPTR_W = $clog2(CMD_CREDITS);

    // Pulse counter has one extra bit on top that flags an active pulse
    localparam int PULSE_W = DATA_W + 1;

    // Cell select
    typedef logic [ADDR_W-1:0] cellAddrT;

    // Level in bit 0, or pulse length in ticks
    typedef logic [DATA_W-1:0] cmdDataT;

    // One bit per pin
    typedef logic [NUM_CELLS-1:0] pinVecT;

    typedef enum logic [1:0] {
        OP_WRITE   = 2'd0,
        OP_RELEASE = 2'd1,
        OP_PULSE   = 2'd2,
        OP_READ    = 2'd3
    } gpioOpT;

endpackage

//--- logic/gpioTickGen.sv
`timescale 1ns/1ps

module gpioTickGen (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    import gpioPkg::*;

    logic [TICK_CNT_W-1:0] divCnt;
    logic                  lastCount;

    assign lastCount = (divCnt == TICK_CNT_W'(TICK_DIV - 1));

    // Free-running modulo counter
    always_ff @(posedge clk) begin
        if (reset) begin
            divCnt <= '0;
        end else if (lastCount) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Tick on the wrap count, so it stays low right after reset
    assign tick = lastCount;

endmodule

//--- tb/gpioChecker.sv
`timescale 1ns/1ps

module gpioChecker (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmdValid,
    input  gpioPkg::gpioOpT   cmdOp,
    input  gpioPkg::cellAddrT cmdAddr,
    input  gpioPkg::cmdDataT  cmdData,
    input  logic              cmdCredit,
    input  logic              rdValid,
    input  gpioPkg::cellAddrT rdAddr,
    input  logic [1:0]        rdData,
    input  gpioPkg::pinVecT   ioIn,
    input  gpioPkg::pinVecT   ioOut,
    input  gpioPkg::pinVecT   ioOutEn,
    output int                errCount,
    output int                checkCount
);
    import gpioPkg::*;

    // Commands accepted but not yet issued
    gpioOpT   qOp   [$];
    cellAddrT qAddr [$];
    cmdDataT  qData [$];

    // Predicted cell state
    pinVecT   level;
    pinVecT   enable;
    pinVecT   pinSample;
    pinVecT   expOut;
    pinVecT   expEn;
    int       pulseLeft [NUM_CELLS];
    int       phase;

    // {enable, level} seen on a pin for a stored state and a running pulse
    function automatic logic [1:0] pinDrive(input logic lvl, input logic en,
                                            input logic pulsing);
        return {en | pulsing, lvl ^ pulsing};
    endfunction

    task automatic flagMismatch(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        errCount++;
    endtask

    initial begin
        errCount   = 0;
        checkCount = 0;
    end

    // Sample mid-cycle, when inputs and outputs are both settled
    always @(negedge clk) begin : compare
        logic       tickNow;
        logic       issue;
        logic [1:0] drive;
        gpioOpT     hOp;
        cellAddrT   hAddr;
        cmdDataT    hData;
        if (reset) begin
            qOp.delete();
            qAddr.delete();
            qData.delete();
            level     = '0;
            enable    = '0;
            pinSample = '0;
            expOut    = '0;
            expEn     = '0;
            foreach (pulseLeft[i]) begin
                pulseLeft[i] = 0;
            end
            phase = 0;
        end else begin
            tickNow = (phase == TICK_DIV - 1);
            issue   = tickNow && (qOp.size() != 0);
            hOp     = OP_WRITE;
            hAddr   = '0;
            hData   = '0;
            if (issue) begin
                hOp   = qOp[0];
                hAddr = qAddr[0];
                hData = qData[0];
            end
            checkCount++;
            if (ioOut !== expOut) begin
                flagMismatch($sformatf("ioOut %b, expected %b", ioOut, expOut));
            end
            if (ioOutEn !== expEn) begin
                flagMismatch($sformatf("ioOutEn %b, expected %b", ioOutEn, expEn));
            end
            if (cmdCredit !== issue) begin
                flagMismatch($sformatf("cmdCredit %b, expected %b", cmdCredit, issue));
            end
            if (rdValid !== (issue && hOp == OP_READ)) begin
                flagMismatch($sformatf("rdValid %b, expected %b", rdValid,
                                       issue && hOp == OP_READ));
            end
            if (issue && hOp == OP_READ) begin
                drive = pinDrive(level[hAddr], enable[hAddr], pulseLeft[hAddr] > 0);
                if (rdAddr !== hAddr) begin
                    flagMismatch($sformatf("rdAddr %0d, expected %0d", rdAddr, hAddr));
                end
                if (rdData !== {drive[0], pinSample[hAddr]}) begin
                    flagMismatch($sformatf("rdData %b for cell %0d, expected %b", rdData,
                                           hAddr, {drive[0], pinSample[hAddr]}));
                end
            end
            if (cmdValid && qOp.size() >= CMD_CREDITS) begin
                $display("ERROR t=%0t: command sent while the queue was full", $time);
                errCount++;
            end
            // What the clock edge at the end of a tick cycle does
            if (tickNow) begin
                for (int i = 0; i < NUM_CELLS; i++) begin
                    drive     = pinDrive(level[i], enable[i], pulseLeft[i] > 0);
                    expEn[i]  = drive[1];
                    expOut[i] = drive[0];
                    if (pulseLeft[i] > 0) begin
                        pulseLeft[i]--;
                    end
                end
                pinSample = ioIn;
                if (issue) begin
                    case (hOp)
                        OP_WRITE: begin
                            level[hAddr]  = hData[0];
                            enable[hAddr] = 1'b1;
                        end
                        OP_RELEASE: begin
                            level[hAddr]  = 1'b0;
                            enable[hAddr] = 1'b0;
                        end
                        OP_PULSE: pulseLeft[hAddr] = int'(hData);
                        default: ;
                    endcase
                    void'(qOp.pop_front());
                    void'(qAddr.pop_front());
                    void'(qData.pop_front());
                end
            end
            if (cmdValid) begin
                qOp.push_back(cmdOp);
                qAddr.push_back(cmdAddr);
                qData.push_back(cmdData);
            end
            phase = tickNow ? 0 : phase + 1;
        end
    end

endmodule

//--- tb/tbGpioBank.sv
`timescale 1ns/1ps

module tbGpioBank;
    import gpioPkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_WRITES  = 12;
    localparam int NUM_PULSES  = 4;
    localparam int MAX_PULSE   = 20;
    localparam int MAX_CMDS    = 48;
    // Every command waiting behind a full queue, every pulse at full length
    localparam int TIMEOUT_CLKS =
        (MAX_CMDS * CMD_CREDITS + NUM_PULSES * (MAX_PULSE + 4) + 64) * TICK_DIV;

    logic       clk;
    logic       reset;
    logic       cmdValid;
    gpioOpT     cmdOp;
    cellAddrT   cmdAddr;
    cmdDataT    cmdData;
    logic       cmdCredit;
    logic       rdValid;
    cellAddrT   rdAddr;
    logic [1:0] rdData;
    pinVecT     ioIn;
    pinVecT     ioOut;
    pinVecT     ioOutEn;

    int chkErrors;
    int chkCount;
    int localErrors;
    int sentCount;
    int returnedCount;
    int testIdx;
    int testsFailed;
    int errMark;

    gpioBank u_gpioBank (
        .clk       (clk),
        .reset     (reset),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdCredit (cmdCredit),
        .rdValid   (rdValid),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .ioIn      (ioIn),
        .ioOut     (ioOut),
        .ioOutEn   (ioOutEn)
    );

    gpioChecker u_checker (
        .clk        (clk),
        .reset      (reset),
        .cmdValid   (cmdValid),
        .cmdOp      (cmdOp),
        .cmdAddr    (cmdAddr),
        .cmdData    (cmdData),
        .cmdCredit  (cmdCredit),
        .rdValid    (rdValid),
        .rdAddr     (rdAddr),
        .rdData     (rdData),
        .ioIn       (ioIn),
        .ioOut      (ioOut),
        .ioOutEn    (ioOutEn),
        .errCount   (chkErrors),
        .checkCount (chkCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Host side credit return
    always @(negedge clk) begin
        if (!reset && cmdCredit === 1'b1) begin
            returnedCount++;
        end
    end

    // Waits for a credit, then holds the command for one cycle
    task automatic sendCmd(input gpioOpT op, input cellAddrT addr, input cmdDataT data);
        while (sentCount - returnedCount >= CMD_CREDITS) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        cmdValid = 1'b1;
        cmdOp    = op;
        cmdAddr  = addr;
        cmdData  = data;
        sentCount++;
        @(posedge clk);
        #DRIVE_DELAY;
        cmdValid = 1'b0;
    endtask

    task automatic waitTicks(input int n);
        repeat (n * TICK_DIV) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // All credits back, then let the pins follow
    task automatic drain();
        while (returnedCount != sentCount) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        waitTicks(2);
    endtask

    task automatic closeTest(input string name);
        int errs;
        errs = chkErrors + localErrors - errMark;
        testIdx++;
        if (errs == 0) begin
            $display("test %0d %s: ok", testIdx, name);
        end else begin
            $display("test %0d %s: %0d errors", testIdx, name, errs);
            testsFailed++;
        end
        errMark = chkErrors + localErrors;
    endtask

    initial begin : stimulus
        cellAddrT addr;
        cmdDataT  len;
        int       mark;
        int       waited;
        int       held;
        void'($urandom(32'h7a7d1974));
        reset         = 1'b1;
        cmdValid      = 1'b0;
        cmdOp         = OP_WRITE;
        cmdAddr       = '0;
        cmdData       = '0;
        ioIn          = '0;
        sentCount     = 0;
        returnedCount = 0;
        localErrors   = 0;
        testIdx       = 0;
        testsFailed   = 0;
        errMark       = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Idle after reset, no credit may come back
        waitTicks(3);
        if (returnedCount != 0) begin
            $display("ERROR t=%0t: credit returned before any command was sent", $time);
            localErrors++;
        end
        closeTest("reset");

        ioIn = pinVecT'($urandom);
        repeat (NUM_WRITES) begin
            sendCmd(OP_WRITE, cellAddrT'($urandom_range(0, NUM_CELLS - 1)), cmdDataT'($urandom));
        end
        drain();
        closeTest("write");

        repeat (3) begin
            addr = cellAddrT'($urandom_range(0, NUM_CELLS - 1));
            sendCmd(OP_RELEASE, addr, '0);
            sendCmd(OP_READ, addr, '0);
        end
        drain();
        closeTest("release");

        // Even passes pulse a driven pin, odd passes a released one
        for (int p = 0; p < NUM_PULSES; p++) begin
            addr = cellAddrT'($urandom_range(0, NUM_CELLS - 1));
            len  = cmdDataT'($urandom_range(1, MAX_PULSE));
            if (p % 2 == 0) begin
                sendCmd(OP_WRITE, addr, cmdDataT'($urandom));
            end else begin
                sendCmd(OP_RELEASE, addr, '0);
            end
            sendCmd(OP_PULSE, addr, len);
            drain();
            waitTicks(int'(len) + 1);
        end
        closeTest("pulse");

        ioIn = pinVecT'($urandom);
        waitTicks(2);
        for (int c = 0; c < NUM_CELLS; c++) begin
            sendCmd(OP_READ, cellAddrT'(c), '0);
        end
        drain();
        closeTest("read");

        mark = returnedCount;
        repeat (CMD_CREDITS) begin
            sendCmd(OP_WRITE, cellAddrT'($urandom_range(0, NUM_CELLS - 1)), cmdDataT'($urandom));
        end
        // One issue per tick, so the burst is out within CMD_CREDITS + 1 ticks
        waited = 0;
        while (returnedCount != sentCount && waited < (CMD_CREDITS + 1) * TICK_DIV) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        held = CMD_CREDITS - (sentCount - returnedCount);
        if (held != CMD_CREDITS) begin
            $display("FAIL t=%0t: host holds %0d credits after the burst, %0d returned, expected %0d",
                     $time, held, returnedCount - mark, CMD_CREDITS);
            localErrors++;
        end
        waitTicks(2);
        closeTest("burst");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testIdx, testsFailed, chkCount, chkErrors + localErrors);
        if (testsFailed == 0 && chkErrors + localErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CLKS * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLKS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
